// ==== src/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  typedef logic [15:0] word_t;
  typedef logic [7:0]  addr_t;

  // instruction class, bits 15:13
  typedef enum logic [2:0] {
    op_ldr  = 3'b011,
    op_str  = 3'b100,
    op_alu  = 3'b101,
    op_mov  = 3'b110,
    op_halt = 3'b111
  } opcode_e;

  typedef enum logic [1:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_not
  } alu_op_e;

  typedef enum logic [1:0] {
    sh_none,
    sh_lsl,
    sh_lsr,
    sh_asr
  } shift_op_e;

  // which instruction field addresses the register file
  typedef enum logic [1:0] {
    sel_rm,
    sel_rd,
    sel_rn
  } reg_sel_e;

  typedef enum logic [1:0] {
    wb_c,
    wb_pc,
    wb_imm8,
    wb_mdata
  } wb_sel_e;

endpackage

`default_nettype wire

// ==== src/ctrl_if.sv ====
`default_nettype none

interface ctrl_if import cpu_pkg::*; ();

  // controller strobes
  logic      load_pc;
  logic      clear_pc;
  logic      load_ir;
  logic      load_addr;
  logic      sel_addr;
  reg_sel_e  reg_sel;
  logic      w_en;
  logic      load_a;
  logic      load_b;
  logic      load_c;
  logic      load_status;
  logic      sel_a;
  logic      sel_b;
  wb_sel_e   wb_sel;

  // decoded instruction fields
  opcode_e   opcode;
  alu_op_e   alu_op;
  shift_op_e shift_op;
  logic [2:0] r_addr;
  logic [2:0] w_addr;
  word_t     sximm5;
  word_t     sximm8;
  addr_t     pc;

  modport ctrl (
    output load_pc, clear_pc, load_ir, load_addr, sel_addr, reg_sel, w_en,
    output load_a, load_b, load_c, load_status, sel_a, sel_b, wb_sel,
    input  opcode, alu_op
  );

  modport fetch (
    input  load_pc, clear_pc, load_ir, load_addr, sel_addr, reg_sel,
    output opcode, alu_op, shift_op, r_addr, w_addr, sximm5, sximm8, pc
  );

  modport dp (
    input w_en, load_a, load_b, load_c, load_status, sel_a, sel_b, wb_sel,
    input alu_op, shift_op, r_addr, w_addr, sximm5, sximm8, pc
  );

endinterface

`default_nettype wire

// ==== src/alu_shifter.sv ====
`default_nettype none

module alu_shifter import cpu_pkg::*; (
  input  word_t     a,
  input  word_t     b,
  input  shift_op_e shift_op,
  input  alu_op_e   alu_op,
  output word_t     result,
  output logic      z,
  output logic      n,
  output logic      v
);

  word_t b_sh;

  always_comb begin
    case (shift_op)
      sh_lsl:  b_sh = b << 1;
      sh_lsr:  b_sh = b >> 1;
      sh_asr:  b_sh = $signed(b) >>> 1;
      default: b_sh = b;
    endcase
  end

  always_comb begin
    v = 1'b0;
    case (alu_op)
      alu_add: begin
        result = a + b_sh;
        v      = (a[15] == b_sh[15]) && (result[15] != a[15]);
      end
      alu_sub: begin
        result = a - b_sh;
        v      = (a[15] != b_sh[15]) && (result[15] != a[15]);
      end
      alu_and: result = a & b_sh;
      default: result = ~b_sh;
    endcase
  end

  assign z = (result == '0);
  assign n = result[15];

endmodule

`default_nettype wire

// ==== src/fetch_decode.sv ====
`default_nettype none

module fetch_decode import cpu_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  addr_t start_pc,
  input  word_t mem_rdata,
  input  word_t dp_out,
  ctrl_if.fetch bus,
  output addr_t mem_addr
);

  addr_t      pc;
  addr_t      data_addr;
  word_t      ir;
  logic [2:0] reg_addr;
  logic       is_mem_op;

  always_ff @(posedge clk) begin
    if (!rst_n || bus.clear_pc)
      pc <= start_pc;
    else if (bus.load_pc)
      pc <= pc + 8'd1;
  end

  always_ff @(posedge clk) begin
    if (bus.load_ir)
      ir <= mem_rdata;
    if (bus.load_addr)
      data_addr <= dp_out[7:0];
  end

  // high selects the pc for instruction fetch
  assign mem_addr = bus.sel_addr ? pc : data_addr;
  assign bus.pc   = pc;

  assign bus.opcode = opcode_e'(ir[15:13]);
  assign is_mem_op  = (bus.opcode == op_ldr) || (bus.opcode == op_str);

  // imm5 overlaps the shift field in ldr/str, so force add with no shift
  assign bus.alu_op   = is_mem_op ? alu_add : alu_op_e'(ir[12:11]);
  assign bus.shift_op = is_mem_op ? sh_none : shift_op_e'(ir[4:3]);

  assign bus.sximm5 = {{11{ir[4]}}, ir[4:0]};
  assign bus.sximm8 = {{8{ir[7]}}, ir[7:0]};

  always_comb begin
    case (bus.reg_sel)
      sel_rm:  reg_addr = ir[2:0];
      sel_rd:  reg_addr = ir[7:5];
      sel_rn:  reg_addr = ir[10:8];
      default: reg_addr = 3'd0;
    endcase
  end

  assign bus.r_addr = reg_addr;
  assign bus.w_addr = reg_addr;

endmodule

`default_nettype wire

// ==== src/control_fsm.sv ====
`default_nettype none

module control_fsm import cpu_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  ctrl_if.ctrl bus,
  output logic mem_we,
  output logic halted
);

  typedef enum logic [4:0] {
    s_reset, s_fetch, s_capture, s_update, s_decode,
    s_mov_imm, s_rd_a, s_rd_b, s_calc, s_pass, s_cmp, s_write_rd,
    s_addr, s_ld_addr, s_ld_mem, s_ld_wb, s_str_mem, s_halt
  } state_e;

  state_e state;
  state_e next_state;
  logic   is_mem_op;
  logic   is_pass;

  assign is_mem_op = (bus.opcode == op_ldr) || (bus.opcode == op_str);
  // mov and mvn ignore operand a
  assign is_pass = (bus.opcode == op_mov) || (bus.alu_op == alu_not);

  always_ff @(posedge clk) begin
    if (!rst_n)
      state <= s_reset;
    else
      state <= next_state;
  end

  always_comb begin
    next_state = s_fetch;
    case (state)
      s_fetch:   next_state = s_capture;
      s_capture: next_state = s_update;
      s_update:  next_state = s_decode;
      s_decode: begin
        case (bus.opcode)
          // sub-op 10 is the immediate form
          op_mov:  next_state = (bus.alu_op == alu_and) ? s_mov_imm : s_rd_b;
          op_alu:  next_state = (bus.alu_op == alu_not) ? s_rd_b : s_rd_a;
          op_ldr:  next_state = s_rd_a;
          op_str:  next_state = s_rd_a;
          op_halt: next_state = s_halt;
          default: next_state = s_fetch;
        endcase
      end
      s_rd_a: next_state = is_mem_op ? s_addr : s_rd_b;
      s_rd_b: begin
        if (bus.opcode == op_alu && bus.alu_op == alu_sub)
          next_state = s_cmp;
        else if (is_pass)
          next_state = s_pass;
        else
          next_state = s_calc;
      end
      s_calc:    next_state = s_write_rd;
      s_pass:    next_state = (bus.opcode == op_str) ? s_str_mem : s_write_rd;
      s_addr:    next_state = s_ld_addr;
      s_ld_addr: next_state = (bus.opcode == op_ldr) ? s_ld_mem : s_pass;
      s_ld_mem:  next_state = s_ld_wb;
      s_halt:    next_state = s_halt;
      default:   next_state = s_fetch;
    endcase
  end

  // strobes from state only
  always_comb begin
    bus.load_pc     = 1'b0;
    bus.clear_pc    = 1'b0;
    bus.load_ir     = 1'b0;
    bus.load_addr   = 1'b0;
    bus.sel_addr    = 1'b0;
    bus.reg_sel     = sel_rm;
    bus.w_en        = 1'b0;
    bus.load_a      = 1'b0;
    bus.load_b      = 1'b0;
    bus.load_c      = 1'b0;
    bus.load_status = 1'b0;
    bus.sel_a       = 1'b0;
    bus.sel_b       = 1'b0;
    bus.wb_sel      = wb_c;
    mem_we          = 1'b0;
    halted          = 1'b0;
    case (state)
      s_reset:   bus.clear_pc = 1'b1;
      s_fetch:   bus.sel_addr = 1'b1;
      s_capture: begin
        bus.sel_addr = 1'b1;
        bus.load_ir  = 1'b1;
      end
      s_update:  bus.load_pc = 1'b1;
      s_mov_imm: begin
        bus.reg_sel = sel_rn;
        bus.wb_sel  = wb_imm8;
        bus.w_en    = 1'b1;
      end
      s_rd_a: begin
        bus.reg_sel = sel_rn;
        bus.load_a  = 1'b1;
      end
      s_rd_b:    bus.load_b = 1'b1;
      s_calc:    bus.load_c = 1'b1;
      s_pass: begin
        bus.sel_a  = 1'b1;
        bus.load_c = 1'b1;
      end
      s_cmp:     bus.load_status = 1'b1;
      s_write_rd: begin
        bus.reg_sel = sel_rd;
        bus.w_en    = 1'b1;
      end
      s_addr: begin
        bus.sel_b  = 1'b1;
        bus.load_c = 1'b1;
      end
      // rd into b here for str
      s_ld_addr: begin
        bus.load_addr = 1'b1;
        bus.reg_sel   = sel_rd;
        bus.load_b    = 1'b1;
      end
      s_ld_wb: begin
        bus.reg_sel = sel_rd;
        bus.wb_sel  = wb_mdata;
        bus.w_en    = 1'b1;
      end
      s_str_mem: mem_we = 1'b1;
      s_halt:    halted = 1'b1;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/datapath.sv ====
`default_nettype none

module datapath import cpu_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  ctrl_if.dp         bus,
  input  word_t      mem_rdata,
  output word_t      dp_out,
  output logic [2:0] status
);

  word_t regs [8];
  word_t a_reg;
  word_t b_reg;
  word_t c_reg;
  word_t r_data;
  word_t w_data;
  word_t alu_a;
  word_t alu_b;
  word_t alu_y;
  logic  z;
  logic  n;
  logic  v;

  assign r_data = regs[bus.r_addr];

  always_comb begin
    case (bus.wb_sel)
      wb_pc:    w_data = {8'h00, bus.pc};
      wb_imm8:  w_data = bus.sximm8;
      wb_mdata: w_data = mem_rdata;
      default:  w_data = c_reg;
    endcase
  end

  always_ff @(posedge clk) begin
    if (bus.w_en)
      regs[bus.w_addr] <= w_data;
    if (bus.load_a)
      a_reg <= r_data;
    if (bus.load_b)
      b_reg <= r_data;
  end

  assign alu_a = bus.sel_a ? '0 : a_reg;
  // imm5 passes the shifter unchanged as decode forces no shift
  assign alu_b = bus.sel_b ? bus.sximm5 : b_reg;

  alu_shifter alu_i (
    .a        (alu_a),
    .b        (alu_b),
    .shift_op (bus.shift_op),
    .alu_op   (bus.alu_op),
    .result   (alu_y),
    .z        (z),
    .n        (n),
    .v        (v)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      c_reg  <= '0;
      status <= '0;
    end else begin
      if (bus.load_c)
        c_reg <= alu_y;
      if (bus.load_status)
        status <= {z, n, v};
    end
  end

  assign dp_out = c_reg;

endmodule

`default_nettype wire

// ==== src/program_ram.sv ====
`default_nettype none

module program_ram import cpu_pkg::*; (
  input  logic  clk,
  input  addr_t mem_addr,
  input  logic  mem_we,
  input  word_t mem_wdata,
  output word_t mem_rdata,
  input  logic  prog_en,
  input  logic  prog_we,
  input  addr_t prog_addr,
  input  word_t prog_wdata,
  output word_t prog_rdata
);

  word_t mem [256];
  addr_t addr;
  logic  we;
  word_t wdata;
  word_t rdata;

  // host port overrides the cpu
  assign addr  = prog_en ? prog_addr : mem_addr;
  assign we    = prog_en ? prog_we : mem_we;
  assign wdata = prog_en ? prog_wdata : mem_wdata;

  always_ff @(posedge clk) begin
    if (we)
      mem[addr] <= wdata;
    rdata <= mem[addr];
  end

  assign mem_rdata  = rdata;
  assign prog_rdata = rdata;

endmodule

`default_nettype wire

// ==== src/cpu_top.sv ====
`default_nettype none

module cpu_top import cpu_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  addr_t      start_pc,
  input  logic       prog_en,
  input  logic       prog_we,
  input  addr_t      prog_addr,
  input  word_t      prog_wdata,
  output word_t      prog_rdata,
  output word_t      out,
  output logic [2:0] status,
  output logic       halted
);

  ctrl_if bus ();

  logic  mem_we;
  addr_t mem_addr;
  word_t mem_rdata;
  word_t dp_out;

  fetch_decode fetch_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .start_pc  (start_pc),
    .mem_rdata (mem_rdata),
    .dp_out    (dp_out),
    .bus       (bus.fetch),
    .mem_addr  (mem_addr)
  );

  control_fsm fsm_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .bus    (bus.ctrl),
    .mem_we (mem_we),
    .halted (halted)
  );

  datapath dp_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus       (bus.dp),
    .mem_rdata (mem_rdata),
    .dp_out    (dp_out),
    .status    (status)
  );

  // c register is both store data and the visible result
  program_ram ram_i (
    .clk        (clk),
    .mem_addr   (mem_addr),
    .mem_we     (mem_we),
    .mem_wdata  (dp_out),
    .mem_rdata  (mem_rdata),
    .prog_en    (prog_en),
    .prog_we    (prog_we),
    .prog_addr  (prog_addr),
    .prog_wdata (prog_wdata),
    .prog_rdata (prog_rdata)
  );

  assign out = dp_out;

endmodule

`default_nettype wire

// ==== test/cpu_tb.sv ====
`default_nettype none

module cpu_tb;

  logic             clk;
  logic             rst_n;
  logic [7:0]       start_pc;
  logic             prog_en;
  logic             prog_we;
  logic [7:0]       prog_addr;
  logic [15:0]      prog_wdata;
  logic [15:0]      prog_rdata;
  logic [15:0]      out;
  logic [2:0]       status;
  logic             halted;

  int               error_count;
  int               check_count;
  int               fd;
  int               code;
  int unsigned      seed_init;
  bit               need_fill;
  bit               finished;
  bit               timed_out;
  logic [7:0]       cmd;
  logic [15:0]      arg_a;
  logic [15:0]      arg_b;
  logic [15:0]      mem_word;
  logic [8*128-1:0] skip_line;

  cpu_top dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_pc   (start_pc),
    .prog_en    (prog_en),
    .prog_we    (prog_we),
    .prog_addr  (prog_addr),
    .prog_wdata (prog_wdata),
    .prog_rdata (prog_rdata),
    .out        (out),
    .status     (status),
    .halted     (halted)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic write_word(input logic [7:0] addr, input logic [15:0] data);
    @(posedge clk);
    prog_en    <= 1'b1;
    prog_we    <= 1'b1;
    prog_addr  <= addr;
    prog_wdata <= data;
  endtask

  // registered read, data one cycle after the address
  task automatic read_word(input logic [7:0] addr, output logic [15:0] data);
    @(posedge clk);
    prog_en   <= 1'b1;
    prog_we   <= 1'b0;
    prog_addr <= addr;
    @(posedge clk);
    @(negedge clk);
    data = prog_rdata;
  endtask

  task automatic fill_random;
    int i;
    @(posedge clk);
    rst_n <= 1'b0;
    for (i = 0; i < 256; i++)
      write_word(8'(i), 16'($urandom()));
  endtask

  task automatic run_program;
    int cycles;
    @(posedge clk);
    rst_n   <= 1'b0;
    prog_en <= 1'b0;
    prog_we <= 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    check_count++;
    if (halted !== 1'b0) begin
      error_count++;
      $display("FAILED halted: expected 0x0, got 0x%01h", halted);
    end
    if (out !== 16'h0000) begin
      error_count++;
      $display("FAILED out: expected 0x0000, got 0x%04h", out);
    end
    if (status !== 3'b000) begin
      error_count++;
      $display("FAILED status: expected 0x0, got 0x%01h", status);
    end
    @(posedge clk);
    rst_n <= 1'b1;
    cycles = 0;
    while (halted !== 1'b1 && cycles < 2000) begin
      @(negedge clk);
      cycles++;
    end
    if (halted !== 1'b1) begin
      error_count++;
      timed_out = 1'b1;
      $display("timeout: the processor did not halt within 2000 cycles");
    end
  endtask

  initial begin
    rst_n      <= 1'b0;
    start_pc   <= 8'h00;
    prog_en    <= 1'b0;
    prog_we    <= 1'b0;
    prog_addr  <= 8'h00;
    prog_wdata <= 16'h0000;
    error_count = 0;
    check_count = 0;
    need_fill   = 1'b1;
    finished    = 1'b0;
    timed_out   = 1'b0;
    seed_init   = $urandom(7062);
    repeat (16) @(posedge clk);
    fd = $fopen("test/cpu_patterns.txt", "r");
    if (fd == 0) begin
      error_count++;
      finished = 1'b1;
      $display("could not open the pattern file test/cpu_patterns.txt");
    end
    while (!finished) begin
      code = $fscanf(fd, " %c", cmd);
      if (code != 1) begin
        error_count++;
        finished = 1'b1;
        $display("pattern file ended without an end record");
      end else begin
        case (cmd)
          "#": code = $fgets(skip_line, fd);
          "L": begin
            code = $fscanf(fd, "%h %h", arg_a, arg_b);
            // fresh random memory before each program
            if (need_fill) begin
              fill_random();
              need_fill = 1'b0;
            end
            write_word(arg_a[7:0], arg_b);
          end
          "S": begin
            code = $fscanf(fd, "%h", arg_a);
            @(posedge clk);
            start_pc <= arg_a[7:0];
          end
          "R": begin
            run_program();
            need_fill = 1'b1;
            if (timed_out)
              finished = 1'b1;
          end
          "O": begin
            code = $fscanf(fd, "%h", arg_a);
            @(negedge clk);
            check_count++;
            if (out !== arg_a) begin
              error_count++;
              $display("FAILED out: expected 0x%04h, got 0x%04h", arg_a, out);
            end
          end
          "F": begin
            code = $fscanf(fd, "%h", arg_a);
            @(negedge clk);
            check_count++;
            if (status !== arg_a[2:0]) begin
              error_count++;
              $display("FAILED status: expected 0x%01h, got 0x%01h", arg_a[2:0], status);
            end
          end
          "M": begin
            code = $fscanf(fd, "%h %h", arg_a, arg_b);
            read_word(arg_a[7:0], mem_word);
            check_count++;
            if (mem_word !== arg_b) begin
              error_count++;
              $display("FAILED mem[%02h]: expected 0x%04h, got 0x%04h",
                       arg_a[7:0], arg_b, mem_word);
            end
          end
          "E": finished = 1'b1;
          default: begin
            error_count++;
            finished = 1'b1;
            $display("unknown record type in the pattern file");
          end
        endcase
      end
    end
    if (fd != 0)
      $fclose(fd);
    $display("checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
src/cpu_pkg.sv
src/ctrl_if.sv
src/alu_shifter.sv
src/fetch_decode.sv
src/control_fsm.sv
src/datapath.sv
src/program_ram.sv
src/cpu_top.sv
test/cpu_tb.sv

// ==== test/cpu_patterns.txt ====
# L addr word: load a word, S addr: start pc, R: run to halt, E: end
# O word: expect out, F zvn: expect status {z,n,v}, M addr word: expect a memory word
# mov, mov, add with lsl, halt
L 00 d005
L 01 d103
L 02 a049
L 03 e000
S 00
R
O 000b
F 0
# cmp of equal values
L 00 d37f
L 01 d47f
L 02 ab04
L 03 e000
S 00
R
O 0000
F 4
# cmp with signed overflow, operands loaded from memory
L 00 d020
L 01 6020
L 02 6041
L 03 a902
L 04 e000
L 20 7fff
L 21 8001
S 00
R
O 0021
F 3
# and with asr, mov with lsr, two stores, then mvn
L 00 d030
L 01 6020
L 02 6041
L 03 b279
L 04 c0b1
L 05 80a2
L 06 8064
L 07 b883
L 08 e000
L 30 f0f0
L 31 3c3c
S 00
R
O c7c7
F 0
M 32 7878
M 34 3838
# str with negative offset, ldr back, str elsewhere
L 00 d650
L 01 d1a5
L 02 863d
L 03 66fd
L 04 86e5
L 05 e000
S 00
R
O ffa5
F 0
M 4d ffa5
M 55 ffa5
# program at 0x80 with an unknown opcode in it
L 80 d211
L 81 1234
L 82 d3f0
L 83 a283
L 84 829f
L 85 e000
S 80
R
O 0001
F 0
M 10 0001
E
